/* list.f */
+incdir+.
rv_core_pkg.sv
rv_idu.sv
rv_exu.sv
rv_wbu.sv
rv_core_top.sv
tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_rv_core -o tb_rv_core

out=$(./obj_dir/tb_rv_core)
echo "$out"

if grep -q "Simulation PASSED" <<< "$out"; then
    exit 0
fi
exit 1

/* rv_core_cfg.svh */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// ##############################
// Core dimensions
// ##############################

`define RV_XLEN   32  // Data path and PC width

`define RV_NREGS  16  // RV32E has sixteen integer registers

`define RV_RIDX_W 4   // Enough to address RV_NREGS entries

`endif

/* rv_core_pkg.sv */
package rv_core_pkg;

`include "rv_core_cfg.svh"

    // ##############################
    // Encodings
    // ##############################

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_JALR   = 7'b1100111,
        OPC_SYSTEM = 7'b1110011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_AUIPC  = 7'b0010111,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_FENCE  = 7'b0001111
    } opcode_e;

    typedef enum logic [9:0] {
        ALU_ADD  = 10'd1,
        ALU_SUB  = 10'd2,
        ALU_SLL  = 10'd4,
        ALU_SLT  = 10'd8,
        ALU_SLTU = 10'd16,
        ALU_XOR  = 10'd32,
        ALU_SRL  = 10'd64,
        ALU_OR   = 10'd128,
        ALU_AND  = 10'd256,
        ALU_SRA  = 10'd512
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL1_REG = 2'b01,
        SEL1_PC  = 2'b10
    } src1_sel_e;

    typedef enum logic [2:0] {
        SEL2_REG = 3'b001,
        SEL2_IMM = 3'b010,
        SEL2_4   = 3'b100
    } src2_sel_e;

    typedef enum logic [2:0] {
        EVT_NONE    = 3'd0,
        EVT_LOAD    = 3'd1,
        EVT_STORE   = 3'd2,
        EVT_CSR     = 3'd3,
        EVT_ECALL   = 3'd4,
        EVT_EBREAK  = 3'd5,
        EVT_MRET    = 3'd6,
        EVT_FENCE_I = 3'd7
    } retire_evt_e;

    // ##############################
    // Stage packets
    // ##############################

    typedef struct packed {
        logic                  valid;
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   imm;
        logic [`RV_RIDX_W-1:0] rd;
        logic                  wen;
        alu_op_e               alu_op;
        src1_sel_e             src1_sel;
        src2_sel_e             src2_sel;
        logic [2:0]            func3;     // Branch condition
        logic                  brch;
        logic                  jal;
        logic                  jalr;
        retire_evt_e           evt;
        logic [`RV_XLEN-1:0]   rs1_val;   // Operands read in the decode cycle
        logic [`RV_XLEN-1:0]   rs2_val;
    } dec_pkt_t;

    typedef struct packed {
        logic                  valid;
        logic [`RV_RIDX_W-1:0] rd;
        logic                  wen;
        logic [`RV_XLEN-1:0]   result;
        logic [`RV_XLEN-1:0]   npc;
        retire_evt_e           evt;
    } exu_res_t;

endpackage

/* rv_core_top.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core_top (
    input  logic                  clock,
    input  logic                  i_arst_n,
    input  logic                  i_valid,
    input  logic [31:0]           i_ins,
    input  logic [`RV_XLEN-1:0]   i_pc,
    output rv_core_pkg::exu_res_t o_ret
);
    import rv_core_pkg::*;

    dec_pkt_t              dec;
    exu_res_t              res;
    logic [`RV_RIDX_W-1:0] rs1_idx;
    logic [`RV_RIDX_W-1:0] rs2_idx;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;

    rv_idu idu_i (
        .i_valid    (i_valid),
        .i_ins      (i_ins),
        .i_pc       (i_pc),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_rs1_idx  (rs1_idx),
        .o_rs2_idx  (rs2_idx),
        .o_dec      (dec)
    );

    rv_exu exu_i (
        .clock    (clock),
        .i_arst_n (i_arst_n),
        .i_dec    (dec),
        .o_res    (res)
    );

    rv_wbu wbu_i (
        .clock      (clock),
        .i_arst_n   (i_arst_n),
        .i_res      (res),
        .i_rs1_idx  (rs1_idx),
        .i_rs2_idx  (rs2_idx),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .o_ret      (o_ret)
    );

endmodule

/* rv_exu.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_exu (
    input  logic                  clock,
    input  logic                  i_arst_n,
    input  rv_core_pkg::dec_pkt_t i_dec,
    output rv_core_pkg::exu_res_t o_res
);
    import rv_core_pkg::*;

    dec_pkt_t            dec_q;
    logic [`RV_XLEN-1:0] op1;
    logic [`RV_XLEN-1:0] op2;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] alu_res;
    logic                br_take;
    logic [`RV_XLEN-1:0] br_tgt;
    logic [`RV_XLEN-1:0] jalr_sum;
    logic [`RV_XLEN-1:0] npc;

    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            dec_q <= '0;
        end else begin
            dec_q <= i_dec;
        end
    end

    // ##############################
    // Operands and ALU
    // ##############################

    // LUI reads x0 through the register select, so operand 1 is zero
    assign op1 = ({`RV_XLEN{dec_q.src1_sel[0]}} & dec_q.rs1_val)
               | ({`RV_XLEN{dec_q.src1_sel[1]}} & dec_q.pc);

    assign op2 = ({`RV_XLEN{dec_q.src2_sel[0]}} & dec_q.rs2_val)
               | ({`RV_XLEN{dec_q.src2_sel[1]}} & dec_q.imm)
               | ({`RV_XLEN{dec_q.src2_sel[2]}} & `RV_XLEN'd4);

    assign shamt = op2[4:0];

    always_comb begin
        case (dec_q.alu_op)
            ALU_SUB:  alu_res = op1 - op2;
            ALU_SLL:  alu_res = op1 << shamt;
            ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, op1 < op2};
            ALU_XOR:  alu_res = op1 ^ op2;
            ALU_SRL:  alu_res = op1 >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(op1) >>> shamt);
            ALU_OR:   alu_res = op1 | op2;
            ALU_AND:  alu_res = op1 & op2;
            default:  alu_res = op1 + op2;
        endcase
    end

    // ##############################
    // Branch and next PC
    // ##############################

    always_comb begin
        case (dec_q.func3)
            3'b000:  br_take = (dec_q.rs1_val == dec_q.rs2_val);
            3'b001:  br_take = (dec_q.rs1_val != dec_q.rs2_val);
            3'b100:  br_take = ($signed(dec_q.rs1_val) < $signed(dec_q.rs2_val));
            3'b101:  br_take = ($signed(dec_q.rs1_val) >= $signed(dec_q.rs2_val));
            3'b110:  br_take = (dec_q.rs1_val < dec_q.rs2_val);
            3'b111:  br_take = (dec_q.rs1_val >= dec_q.rs2_val);
            default: br_take = 1'b0;
        endcase
    end

    assign br_tgt   = dec_q.pc + dec_q.imm;
    assign jalr_sum = dec_q.rs1_val + dec_q.imm;

    always_comb begin
        if (dec_q.jalr) npc = {jalr_sum[`RV_XLEN-1:1], 1'b0};
        else if (dec_q.jal || (dec_q.brch && br_take)) npc = br_tgt;
        else npc = dec_q.pc + `RV_XLEN'd4;
    end

    always_comb begin
        o_res.valid  = dec_q.valid;
        o_res.rd     = dec_q.rd;
        o_res.wen    = dec_q.wen;
        o_res.result = alu_res;
        o_res.npc    = npc;
        o_res.evt    = dec_q.evt;
    end

endmodule

/* rv_idu.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_idu (
    input  logic                  i_valid,
    input  logic [31:0]           i_ins,
    input  logic [`RV_XLEN-1:0]   i_pc,
    input  logic [`RV_XLEN-1:0]   i_rs1_data,
    input  logic [`RV_XLEN-1:0]   i_rs2_data,
    output logic [`RV_RIDX_W-1:0] o_rs1_idx,
    output logic [`RV_RIDX_W-1:0] o_rs2_idx,
    output rv_core_pkg::dec_pkt_t o_dec
);
    import rv_core_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            func3;
    logic                  f7_alt;
    logic [`RV_RIDX_W-1:0] rd;
    logic [`RV_RIDX_W-1:0] rs1;
    logic [`RV_RIDX_W-1:0] rs2;
    logic                  is_op_imm;
    logic                  is_op;
    logic                  is_load;
    logic                  is_store;
    logic                  is_lui;
    logic                  is_auipc;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_brch;
    logic                  is_fence;
    logic                  is_system;
    logic                  is_csr;
    logic [`RV_XLEN-1:0]   imm;
    alu_op_e               alu_op;
    src1_sel_e             sel1;
    src2_sel_e             sel2;
    retire_evt_e           evt;

    assign opcode = i_ins[6:0];
    assign func3  = i_ins[14:12];
    assign f7_alt = i_ins[30];              // funct7 bit 5 picks SUB and SRA
    assign rd     = i_ins[7 +: `RV_RIDX_W];
    assign rs1    = i_ins[15 +: `RV_RIDX_W];
    assign rs2    = i_ins[20 +: `RV_RIDX_W];

    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign is_op     = (opcode == OPC_OP);
    assign is_load   = (opcode == OPC_LOAD);
    assign is_store  = (opcode == OPC_STORE);
    assign is_lui    = (opcode == OPC_LUI);
    assign is_auipc  = (opcode == OPC_AUIPC);
    assign is_jal    = (opcode == OPC_JAL);
    assign is_jalr   = (opcode == OPC_JALR);
    assign is_brch   = (opcode == OPC_BRANCH);
    assign is_fence  = (opcode == OPC_FENCE);
    assign is_system = (opcode == OPC_SYSTEM);
    assign is_csr    = is_system && (func3 != 3'b000);

    // ##############################
    // Immediate and operation
    // ##############################

    always_comb begin
        imm = '0;
        if (is_op_imm || is_load || is_jalr) begin
            imm = {{20{i_ins[31]}}, i_ins[31:20]};
        end else if (is_lui || is_auipc) begin
            imm = {i_ins[31:12], 12'b0};
        end else if (is_jal) begin
            imm = {{12{i_ins[31]}}, i_ins[19:12], i_ins[20], i_ins[30:21], 1'b0};
        end else if (is_brch) begin
            imm = {{20{i_ins[31]}}, i_ins[7], i_ins[30:25], i_ins[11:8], 1'b0};
        end else if (is_store) begin
            imm = {{20{i_ins[31]}}, i_ins[31:25], i_ins[11:7]};
        end
    end

    always_comb begin
        alu_op = ALU_ADD;                   // Address and link arithmetic
        if (is_op || is_op_imm) begin
            case (func3)
                3'b000:  alu_op = (is_op && f7_alt) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = f7_alt ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end else if (is_csr && func3 == 3'b010) begin
            alu_op = ALU_OR;
        end
    end

    assign sel1 = (is_auipc || is_jal || is_jalr) ? SEL1_PC : SEL1_REG;

    always_comb begin
        sel2 = SEL2_REG;
        if (is_op_imm || is_lui || is_auipc || is_load || is_store) begin
            sel2 = SEL2_IMM;
        end else if (is_jal || is_jalr) begin
            sel2 = SEL2_4;                  // Link value is PC+4
        end else if (is_csr && func3 == 3'b001) begin
            sel2 = SEL2_IMM;
        end
    end

    always_comb begin
        evt = EVT_NONE;
        if (is_load) evt = EVT_LOAD;
        else if (is_store) evt = EVT_STORE;
        else if (is_csr) evt = EVT_CSR;
        else if (is_system && rs2[1:0] == 2'b00) evt = EVT_ECALL;
        else if (is_system && rs2[1:0] == 2'b01) evt = EVT_EBREAK;
        else if (is_system && rs2[1:0] == 2'b10) evt = EVT_MRET;
        else if (is_fence && func3 == 3'b001) evt = EVT_FENCE_I;
    end

    assign o_rs1_idx = (is_lui || is_auipc || is_jal) ? '0 : rs1;
    assign o_rs2_idx = (is_op || is_brch || is_store) ? rs2 : '0;

    always_comb begin
        o_dec.valid    = i_valid;
        o_dec.pc       = i_pc;
        o_dec.imm      = imm;
        o_dec.rd       = rd;
        o_dec.wen      = is_op_imm || is_op || is_lui || is_auipc || is_jal || is_jalr;
        o_dec.alu_op   = alu_op;
        o_dec.src1_sel = sel1;
        o_dec.src2_sel = sel2;
        o_dec.func3    = func3;
        o_dec.brch     = is_brch;
        o_dec.jal      = is_jal;
        o_dec.jalr     = is_jalr;
        o_dec.evt      = evt;
        o_dec.rs1_val  = i_rs1_data;
        o_dec.rs2_val  = i_rs2_data;
    end

endmodule

/* rv_wbu.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_wbu (
    input  logic                  clock,
    input  logic                  i_arst_n,
    input  rv_core_pkg::exu_res_t i_res,
    input  logic [`RV_RIDX_W-1:0] i_rs1_idx,
    input  logic [`RV_RIDX_W-1:0] i_rs2_idx,
    output logic [`RV_XLEN-1:0]   o_rs1_data,
    output logic [`RV_XLEN-1:0]   o_rs2_data,
    output rv_core_pkg::exu_res_t o_ret
);
    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic                wr_en;

    // ##############################
    // Register file
    // ##############################

    assign wr_en = i_res.valid && i_res.wen && (i_res.rd != '0);  // x0 is never written

    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_res.rd] <= i_res.result;
        end
    end

    // Result about to be written wins over the stored value
    function automatic logic [`RV_XLEN-1:0] rd_port(
        input logic [`RV_RIDX_W-1:0] idx,
        input logic [`RV_XLEN-1:0]   rf_val,
        input exu_res_t              res
    );
        logic hit;
        hit = res.valid && res.wen && (res.rd == idx);
        if (idx == '0) begin
            return '0;
        end
        return hit ? res.result : rf_val;
    endfunction

    assign o_rs1_data = rd_port(i_rs1_idx, regs[i_rs1_idx], i_res);
    assign o_rs2_data = rd_port(i_rs2_idx, regs[i_rs2_idx], i_res);

    // ##############################
    // Retirement
    // ##############################

    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ret <= '0;
        end else begin
            o_ret <= i_res;                 // Same edge as the register write
        end
    end

endmodule

/* tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module tb_rv_core;
    import rv_core_pkg::*;

    logic                clock;
    logic                i_arst_n;
    logic                i_valid;
    logic [31:0]         i_ins;
    logic [`RV_XLEN-1:0] i_pc;
    exu_res_t            o_ret;

    logic [`RV_XLEN-1:0] mregs [`RV_NREGS];   // Reference register file
    logic [`RV_XLEN-1:0] pc;
    exu_res_t            exp_q [$];
    string               name_q [$];
    int                  cyc_q [$];
    exu_res_t            exp_ret;
    string               exp_name;
    int                  exp_cyc;
    int                  cyc = 0;
    int                  n_issued = 0;
    int                  n_ret = 0;
    int                  errors = 0;
    integer              seed;

    rv_core_top dut_i (
        .clock    (clock),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .i_ins    (i_ins),
        .i_pc     (i_pc),
        .o_ret    (o_ret)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) cyc <= cyc + 1;

    // ##############################
    // Encoders and reference model
    // ##############################

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [3:0] rs2,
                                          input logic [3:0] rs1, input logic [2:0] f3,
                                          input logic [3:0] rd, input logic [6:0] opc);
        return {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [3:0] rs1,
                                          input logic [2:0] f3, input logic [3:0] rd,
                                          input logic [6:0] opc);
        return {imm, 1'b0, rs1, f3, 1'b0, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [3:0] rd,
                                          input logic [6:0] opc);
        return {imm, 1'b0, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [3:0] rs2,
                                          input logic [3:0] rs1, input logic [2:0] f3);
        return {imm[11:5], 1'b0, rs2, 1'b0, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [3:0] rs2,
                                          input logic [3:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], 1'b0, rs2, 1'b0, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [3:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 1'b0, rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
        logic [31:0] z;
        case (f3)
            3'b000:  z = alt ? x - y : x + y;
            3'b001:  z = x << y[4:0];
            3'b010:  z = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011:  z = (x < y) ? 32'd1 : 32'd0;
            3'b100:  z = x ^ y;
            3'b110:  z = x | y;
            3'b111:  z = x & y;
            default: begin
                if (alt) z = $unsigned($signed(x) >>> y[4:0]);
                else z = x >> y[4:0];
            end
        endcase
        return z;
    endfunction

    // Executes one instruction on the model and returns what must retire
    function automatic exu_res_t exec_ref(input logic [31:0] ins, input logic [31:0] at_pc);
        exu_res_t    r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [2:0]  f3;
        logic        take;
        f3    = ins[14:12];
        a     = mregs[ins[18:15]];
        b     = mregs[ins[23:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        r       = '0;
        r.valid = 1'b1;
        r.rd    = ins[10:7];
        r.npc   = at_pc + 32'd4;
        r.evt   = EVT_NONE;
        case (ins[6:0])
            OPC_OP: begin
                r.wen    = 1'b1;
                r.result = alu_ref(f3, ins[30], a, b);
            end
            OPC_OP_IMM: begin
                r.wen    = 1'b1;
                r.result = alu_ref(f3, ins[30] && f3 == 3'b101, a, imm_i);
            end
            OPC_LUI: begin
                r.wen    = 1'b1;
                r.result = {ins[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                r.wen    = 1'b1;
                r.result = at_pc + {ins[31:12], 12'b0};
            end
            OPC_JAL: begin
                r.wen    = 1'b1;
                r.result = at_pc + 32'd4;
                r.npc    = at_pc + imm_j;
            end
            OPC_JALR: begin
                r.wen    = 1'b1;
                r.result = at_pc + 32'd4;
                r.npc    = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                // Bits 2:1 pick the comparison and bit 0 negates it
                case (f3[2:1])
                    2'b00:   take = (a == b);
                    2'b10:   take = ($signed(a) < $signed(b));
                    2'b11:   take = (a < b);
                    default: take = 1'b0;
                endcase
                if (f3[2:1] != 2'b01 && f3[0]) take = !take;
                if (take) r.npc = at_pc + imm_b;
            end
            OPC_LOAD:  r.evt = EVT_LOAD;
            OPC_STORE: r.evt = EVT_STORE;
            OPC_SYSTEM: begin
                if (f3 != 3'b000) r.evt = EVT_CSR;
                else if (ins[21:20] == 2'b00) r.evt = EVT_ECALL;
                else if (ins[21:20] == 2'b01) r.evt = EVT_EBREAK;
                else r.evt = EVT_MRET;
            end
            OPC_FENCE: if (f3 == 3'b001) r.evt = EVT_FENCE_I;
            default: ;
        endcase
        if (r.wen && r.rd != 0) mregs[r.rd] = r.result;
        return r;
    endfunction

    function automatic logic [31:0] rand_ins();
        logic [31:0] r;
        logic [31:0] v;
        logic [2:0]  f3;
        logic [11:0] imm;
        r  = $random(seed);
        v  = $random(seed);
        f3 = r[5:3];
        case (r[1:0])
            2'd0: return enc_r({1'b0, r[2], 5'b0}, v[11:8], v[7:4], f3, v[3:0], OPC_OP);
            2'd1: begin
                imm = v[31:20];
                if (f3 == 3'b001) imm = {7'b0, v[24:20]};
                if (f3 == 3'b101) imm = {1'b0, r[2], 5'b0, v[24:20]};
                return enc_i(imm, v[7:4], f3, v[3:0], OPC_OP_IMM);
            end
            2'd2: return enc_u(v[31:12], v[3:0], r[2] ? OPC_AUIPC : OPC_LUI);
            default: begin
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;   // No branch uses func3 010 or 011
                return enc_b({v[31:20], 1'b0}, r[6] ? v[7:4] : v[11:8], v[7:4], f3);
            end
        endcase
    endfunction

    // ##############################
    // Drive and compare
    // ##############################

    task automatic issue(input string name, input logic [31:0] ins);
        @(posedge clock);
        #1;
        exp_q.push_back(exec_ref(ins, pc));
        name_q.push_back(name);
        cyc_q.push_back(cyc);
        i_valid = 1'b1;
        i_ins   = ins;
        i_pc    = pc;
        n_issued++;
        pc = pc + 32'd4;
    endtask

    task automatic drain();
        @(posedge clock);
        #1;
        i_valid = 1'b0;
        while (exp_q.size() != 0) @(posedge clock);
        repeat (4) @(posedge clock);
    endtask

    task automatic check_ret(input string name, input exu_res_t exp, input exu_res_t act);
        if (exp.wen !== act.wen || exp.rd !== act.rd || exp.evt !== act.evt
                || (exp.wen && exp.result !== act.result)) begin
            errors++;
            $write("FAIL %s: expected wen=%0b rd=%0d result=%h evt=%0d, ",
                   name, exp.wen, exp.rd, exp.result, exp.evt);
            $display("actual wen=%0b rd=%0d result=%h evt=%0d",
                     act.wen, act.rd, act.result, act.evt);
        end
    endtask

    task automatic check_pc(input string name, input logic [`RV_XLEN-1:0] exp,
                            input logic [`RV_XLEN-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: expected npc=%h, actual npc=%h", name, exp, act);
        end
    endtask

    always @(negedge clock) begin
        if (i_arst_n && o_ret.valid) begin
            n_ret++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("A retirement arrived with no instruction in flight (rd=%0d)", o_ret.rd);
            end else begin
                exp_ret  = exp_q.pop_front();
                exp_name = name_q.pop_front();
                exp_cyc  = cyc_q.pop_front();
                if (cyc != exp_cyc + 2) begin
                    errors++;
                    $display("%s retired %0d cycles after it was presented instead of 2",
                             exp_name, cyc - exp_cyc);
                end
                check_ret(exp_name, exp_ret, o_ret);
                check_pc(exp_name, exp_ret.npc, o_ret.npc);
            end
        end
    end

    always @(posedge clock) begin
        if (cyc > 4 * n_issued + 100) begin
            $display("Timeout after %0d cycles, %0d instructions never retired",
                     cyc, exp_q.size());
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ##############################
    // Stimulus
    // ##############################

    initial begin
        seed     = 32;
        pc       = 32'h0000_1000;
        i_arst_n = 1'b0;
        i_valid  = 1'b0;
        i_ins    = '0;
        i_pc     = '0;
        for (int i = 0; i < `RV_NREGS; i++) mregs[i] = '0;
        repeat (16) @(posedge clock);
        #1;
        i_arst_n = 1'b1;

        issue("addi_neg", enc_i(12'hffb, 0, 3'b000, 1, OPC_OP_IMM));   // x1 = -5
        issue("addi_pos", enc_i(12'h003, 0, 3'b000, 2, OPC_OP_IMM));   // x2 = 3
        issue("lui", enc_u(20'h80000, 3, OPC_LUI));
        issue("add", enc_r(7'h00, 2, 1, 3'b000, 4, OPC_OP));
        issue("sub", enc_r(7'h20, 2, 1, 3'b000, 5, OPC_OP));
        issue("sll", enc_r(7'h00, 2, 1, 3'b001, 6, OPC_OP));
        issue("slt", enc_r(7'h00, 2, 1, 3'b010, 7, OPC_OP));
        issue("sltu", enc_r(7'h00, 2, 1, 3'b011, 8, OPC_OP));
        issue("xor", enc_r(7'h00, 2, 1, 3'b100, 9, OPC_OP));
        issue("srl", enc_r(7'h00, 2, 3, 3'b101, 10, OPC_OP));
        issue("sra", enc_r(7'h20, 2, 3, 3'b101, 11, OPC_OP));
        issue("or", enc_r(7'h00, 2, 1, 3'b110, 12, OPC_OP));
        issue("and", enc_r(7'h00, 2, 1, 3'b111, 13, OPC_OP));
        issue("slti", enc_i(12'hfff, 1, 3'b010, 14, OPC_OP_IMM));
        issue("sltiu", enc_i(12'h005, 1, 3'b011, 15, OPC_OP_IMM));
        issue("xori", enc_i(12'h0f0, 1, 3'b100, 4, OPC_OP_IMM));
        issue("ori", enc_i(12'h800, 2, 3'b110, 5, OPC_OP_IMM));
        issue("andi", enc_i(12'h7fe, 1, 3'b111, 6, OPC_OP_IMM));
        issue("slli", enc_i(12'h01f, 2, 3'b001, 7, OPC_OP_IMM));
        issue("srli", enc_i(12'h004, 3, 3'b101, 8, OPC_OP_IMM));
        issue("srai", enc_i(12'h404, 3, 3'b101, 9, OPC_OP_IMM));
        issue("auipc", enc_u(20'h12345, 10, OPC_AUIPC));
        drain();

        // Each result feeds the very next instruction
        issue("bypass_addi", enc_i(12'h007, 0, 3'b000, 4, OPC_OP_IMM));
        issue("bypass_add", enc_r(7'h00, 4, 4, 3'b000, 5, OPC_OP));
        issue("bypass_sub", enc_r(7'h20, 4, 5, 3'b000, 6, OPC_OP));
        issue("bypass_xor", enc_r(7'h00, 5, 6, 3'b100, 7, OPC_OP));
        issue("bypass_gap", enc_r(7'h00, 6, 5, 3'b000, 8, OPC_OP));
        drain();

        issue("beq_taken", enc_b(13'h0010, 2, 2, 3'b000));
        issue("beq_not", enc_b(13'h0010, 2, 1, 3'b000));
        issue("bne_taken", enc_b(13'h1ff8, 2, 1, 3'b001));
        issue("bne_not", enc_b(13'h1ff8, 2, 2, 3'b001));
        issue("blt_taken", enc_b(13'h0020, 2, 1, 3'b100));
        issue("blt_not", enc_b(13'h0020, 1, 2, 3'b100));
        issue("bge_taken", enc_b(13'h0ffe, 1, 2, 3'b101));
        issue("bge_not", enc_b(13'h0ffe, 2, 1, 3'b101));
        issue("bltu_taken", enc_b(13'h1000, 1, 2, 3'b110));
        issue("bltu_not", enc_b(13'h1000, 2, 1, 3'b110));
        issue("bgeu_taken", enc_b(13'h0040, 2, 1, 3'b111));
        issue("bgeu_not", enc_b(13'h0040, 1, 2, 3'b111));
        issue("jal", enc_j(21'h000100, 8));
        issue("jalr", enc_i(12'h006, 2, 3'b000, 9, OPC_JALR));   // Target 9 loses bit 0
        issue("link_sum", enc_r(7'h00, 9, 8, 3'b000, 10, OPC_OP));
        drain();

        issue("load", enc_i(12'h004, 2, 3'b010, 11, OPC_LOAD));
        issue("load_nowrite", enc_r(7'h00, 0, 11, 3'b000, 12, OPC_OP));
        issue("store", enc_s(12'h008, 1, 2, 3'b010));
        issue("csrrw", enc_i(12'h300, 1, 3'b001, 13, OPC_SYSTEM));
        issue("csrrs", enc_i(12'h300, 2, 3'b010, 13, OPC_SYSTEM));
        issue("csr_nowrite", enc_r(7'h00, 0, 13, 3'b000, 14, OPC_OP));
        issue("ecall", 32'h0000_0073);
        issue("ebreak", 32'h0010_0073);
        issue("mret", 32'h3020_0073);
        issue("fence_i", 32'h0000_100f);
        issue("write_x0", enc_i(12'h009, 2, 3'b000, 0, OPC_OP_IMM));
        issue("read_x0", enc_r(7'h00, 2, 0, 3'b000, 15, OPC_OP));
        drain();

        for (int k = 0; k < 400; k++) begin
            issue("random", rand_ins());
        end
        drain();

        $display("Run complete: %0d issued, %0d retired, %0d errors", n_issued, n_ret, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
